/* logic/kersram_params.svh */
// ==============================
// kernel sram read sequencer
// project-wide widths, bank count and sram read latency
// ==============================
`ifndef KERSRAM_PARAMS_SVH
`define KERSRAM_PARAMS_SVH

// sram address width, also the word and column counter width
`define KS_ADDR_BITS 10

// kernel counter width
`define KS_KER_BITS 8

// top starter and pad length width
`define KS_OFS_BITS 8

// kernel sram banks, each one cycle behind the one before
`define KS_BANKS 8

// cycles from cen low to read data at the sram output
`define KS_RD_LAT 1

`endif

/* logic/kersram_pkg.sv */
// ==============================
// kernel sram read sequencer types
// row kind, fsm states, config and bank port structs
// ==============================
`include "kersram_params.svh"

package kersram_pkg;

	// ==============================
	// enums
	// ==============================

	// which ifmap row the kernel slice is read for
	typedef enum logic [1:0] {
		ROW_MID = 2'd0,
		ROW_TOP = 2'd1,
		ROW_BOT = 2'd2
	} row_kind_e;

	// start / busy / done session
	typedef enum logic [1:0] {
		SESS_IDLE = 2'd0,
		SESS_BUSY = 2'd1,
		SESS_DONE = 2'd2
	} sess_state_e;

	// read mode while the session is busy
	typedef enum logic [1:0] {
		RD_IDLE  = 2'd0,
		PAD_MODE = 2'd1,
		NOR_MODE = 2'd2,
		RD_DONE  = 2'd3
	} rd_state_e;

	// ==============================
	// structs
	// ==============================

	// session config, held stable from start until done
	typedef struct packed {
		row_kind_e                row_kind;
		logic [`KS_OFS_BITS-1:0]  top_starter;
		logic [`KS_OFS_BITS-1:0]  toppad_length;
		logic [`KS_OFS_BITS-1:0]  botpad_length;
		logic [`KS_ADDR_BITS-1:0] normal_length;
		logic [`KS_ADDR_BITS-1:0] colout_sub1;
		logic [`KS_KER_BITS-1:0]  kernum_sub1;
	} read_cfg_t;

	// one bank, cen is active low
	typedef struct packed {
		logic                     cen;
		logic [`KS_ADDR_BITS-1:0] addr;
		logic                     valid;
		logic                     final_flag;
	} bank_port_t;

endpackage

/* logic/kernel_read_ctrl.sv */
`timescale 1ns/1ps
// ==============================
// kernel read control
// session fsm turns start into busy and done
// read-mode fsm picks pad or normal sweep and runs it
// ==============================
module kernel_read_ctrl import kersram_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      start_ker_read,
	input  row_kind_e row_kind,
	input  logic      sweep_last,
	output logic      sweep_en,
	output logic      pad_sel,
	output logic      ker_read_busy,
	output logic      ker_read_done
);

	sess_state_e sess_state;
	sess_state_e sess_next;
	rd_state_e   rd_state;
	rd_state_e   rd_next;
	// start only counts while idle
	logic        start_ok;
	// one cycle after an accepted start
	logic        launch;

	assign start_ok = (sess_state == SESS_IDLE) && start_ker_read;

	// ==============================
	// session fsm
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			sess_state <= SESS_IDLE;
			launch <= 1'b0;
		end else begin
			sess_state <= sess_next;
			launch <= start_ok;
		end
	end

	always_comb begin
		case (sess_state)
			SESS_IDLE: sess_next = start_ok ? SESS_BUSY : SESS_IDLE;
			// done pulse closes the session, busy drops next cycle
			SESS_BUSY: sess_next = ker_read_done ? SESS_DONE : SESS_BUSY;
			SESS_DONE: sess_next = SESS_IDLE;
			default: sess_next = SESS_IDLE;
		endcase
	end

	assign ker_read_busy = (sess_state == SESS_BUSY);

	// ==============================
	// read-mode fsm
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_state <= RD_IDLE;
		end else begin
			rd_state <= rd_next;
		end
	end

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			// top and bottom rows both take the padding path
			RD_IDLE: begin
				if (launch) begin
					rd_next = (row_kind == ROW_MID) ? NOR_MODE : PAD_MODE;
				end
			end
			PAD_MODE, NOR_MODE: begin
				if (sweep_last) begin
					rd_next = RD_DONE;
				end
			end
			RD_DONE: rd_next = RD_IDLE;
			default: rd_next = RD_IDLE;
		endcase
	end

	assign sweep_en = (rd_state == PAD_MODE) || (rd_state == NOR_MODE);
	assign pad_sel = (rd_state == PAD_MODE);

	// done lands the cycle after RD_DONE
	always_ff @(posedge clk) begin
		if (reset) begin
			ker_read_done <= 1'b0;
		end else begin
			ker_read_done <= (rd_state == RD_DONE);
		end
	end

endmodule

/* logic/addr_sweep.sv */
`timescale 1ns/1ps
// ==============================
// address sweep
// word, column and kernel counters, nested in that order
// forms the sram address and flags slice and sweep ends
// ==============================
`include "kersram_params.svh"

module addr_sweep import kersram_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  read_cfg_t                cfg,
	input  logic                     sweep_en,
	input  logic                     pad_sel,
	output logic                     sweep_last,
	output logic                     issue,
	output logic [`KS_ADDR_BITS-1:0] issue_addr,
	output logic                     slice_last
);

	localparam int OFS_EXT = `KS_ADDR_BITS - `KS_OFS_BITS;

	logic [`KS_ADDR_BITS-1:0] slice_len;
	logic [`KS_ADDR_BITS-1:0] offset;
	logic [`KS_ADDR_BITS-1:0] ker_base;
	logic [`KS_ADDR_BITS-1:0] word_cnt;
	logic [`KS_ADDR_BITS-1:0] col_cnt;
	logic [`KS_KER_BITS-1:0]  ker_cnt;
	logic                     col_last;
	logic                     ker_last;

	// ==============================
	// slice length and offset
	// ==============================
	always_comb begin
		slice_len = cfg.normal_length;
		offset = '0;
		if (pad_sel) begin
			// top padding skips the leading rows of the kernel
			if (cfg.row_kind == ROW_TOP) begin
				slice_len = {{OFS_EXT{1'b0}}, cfg.toppad_length};
				offset = {{OFS_EXT{1'b0}}, cfg.top_starter};
			end else begin
				slice_len = {{OFS_EXT{1'b0}}, cfg.botpad_length};
			end
		end
	end

	// ==============================
	// end detection
	// ==============================
	assign slice_last = sweep_en && (word_cnt == slice_len - 1'b1);
	assign col_last = (col_cnt == cfg.colout_sub1);
	assign ker_last = (ker_cnt == cfg.kernum_sub1);
	assign sweep_last = slice_last && col_last && ker_last;

	// ==============================
	// counters
	// ==============================
	// all three wrap to 0, so the next session starts clean
	always_ff @(posedge clk) begin
		if (reset) begin
			word_cnt <= '0;
			col_cnt <= '0;
			ker_cnt <= '0;
		end else if (sweep_en) begin
			word_cnt <= slice_last ? '0 : word_cnt + 1'b1;
			if (slice_last) begin
				col_cnt <= col_last ? '0 : col_cnt + 1'b1;
				if (col_last) begin
					ker_cnt <= ker_last ? '0 : ker_cnt + 1'b1;
				end
			end
		end
	end

	// kernel stride is always the full normal length
	assign ker_base = {{(`KS_ADDR_BITS - `KS_KER_BITS){1'b0}}, ker_cnt} * cfg.normal_length;
	assign issue_addr = offset + ker_base + word_cnt;
	assign issue = sweep_en;

endmodule

/* logic/bank_stagger.sv */
`timescale 1ns/1ps
// ==============================
// bank stagger
// delays strobe, address and final mark one cycle per bank
// valid and final trail cen by the sram read latency
// ==============================
`include "kersram_params.svh"

module bank_stagger import kersram_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     issue,
	input  logic [`KS_ADDR_BITS-1:0] issue_addr,
	input  logic                     slice_last,
	output bank_port_t               banks [`KS_BANKS]
);

	// bank taps plus the read latency stages
	localparam int DEPTH = `KS_BANKS + `KS_RD_LAT;

	logic [DEPTH-1:0]         stb_q;
	logic [DEPTH-1:0]         fin_q;
	logic [`KS_ADDR_BITS-1:0] addr_q [`KS_BANKS];

	// ==============================
	// delay lines
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			stb_q <= '0;
			fin_q <= '0;
		end else begin
			stb_q <= {stb_q[DEPTH-2:0], issue};
			// final only for a word that closed its slice
			fin_q <= {fin_q[DEPTH-2:0], issue & slice_last};
		end
	end

	// address delay line with one stage per bank
	always_ff @(posedge clk) begin
		addr_q[0] <= issue_addr;
		for (int k = 1; k < `KS_BANKS; k++) begin
			addr_q[k] <= addr_q[k-1];
		end
	end

	// ==============================
	// bank outputs
	// ==============================
	always_comb begin
		for (int k = 0; k < `KS_BANKS; k++) begin
			banks[k].cen = ~stb_q[k];
			// idle banks see address 0
			banks[k].addr = stb_q[k] ? addr_q[k] : '0;
			banks[k].valid = stb_q[k + `KS_RD_LAT];
			banks[k].final_flag = fin_q[k + `KS_RD_LAT];
		end
	end

endmodule

/* logic/kersram_read.sv */
`timescale 1ns/1ps
// ==============================
// kernel sram read sequencer top
// control, address sweep and bank stagger
// ==============================
`include "kersram_params.svh"

module kersram_read import kersram_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start_ker_read,
	input  read_cfg_t  cfg,
	output logic       ker_read_busy,
	output logic       ker_read_done,
	output bank_port_t banks [`KS_BANKS]
);

	// ctrl to sweep
	logic                     sweep_en;
	logic                     pad_sel;
	logic                     sweep_last;
	// sweep to stagger
	logic                     issue;
	logic [`KS_ADDR_BITS-1:0] issue_addr;
	logic                     slice_last;

	kernel_read_ctrl u_ctrl (
		.clk            (clk),
		.reset          (reset),
		.start_ker_read (start_ker_read),
		.row_kind       (cfg.row_kind),
		.sweep_last     (sweep_last),
		.sweep_en       (sweep_en),
		.pad_sel        (pad_sel),
		.ker_read_busy  (ker_read_busy),
		.ker_read_done  (ker_read_done)
	);

	addr_sweep u_sweep (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.sweep_en   (sweep_en),
		.pad_sel    (pad_sel),
		.sweep_last (sweep_last),
		.issue      (issue),
		.issue_addr (issue_addr),
		.slice_last (slice_last)
	);

	bank_stagger u_stagger (
		.clk        (clk),
		.reset      (reset),
		.issue      (issue),
		.issue_addr (issue_addr),
		.slice_last (slice_last),
		.banks      (banks)
	);

endmodule

/* tests/kersram_read_tb.sv */
`timescale 1ns/1ps
// ==============================
// kernel sram read sequencer testbench
// replays file cases against an address model
// checks bank stagger, valid, final and the handshake
// ==============================
`include "kersram_params.svh"

module kersram_read_tb import kersram_pkg::*; ();

	localparam int NCOLS = 9;
	localparam int MAX_CASES = 16;
	localparam int PERIOD = 20;

	logic       clk;
	logic       reset;
	logic       start_ker_read;
	read_cfg_t  cfg;
	logic       ker_read_busy;
	logic       ker_read_done;
	bank_port_t banks [`KS_BANKS];

	// nine hex columns per case as laid out in the cases file
	logic [31:0] case_mem [MAX_CASES*NCOLS];
	int          n_cases;
	logic        loaded;
	logic [31:0] seed;
	int          cyc = 0;
	logic        mon_on;
	// model output with one entry per issued word
	int          exp_addr [$];
	logic        exp_fin [$];
	// cycles where bank 0 had cen low
	int          b0_cyc [$];
	int          low_cnt [`KS_BANKS];
	int          val_cnt [`KS_BANKS];
	int          fin_cnt [`KS_BANKS];
	logic        prev_low [`KS_BANKS];
	int          done_cnt;
	logic        prev_done;

	kersram_read u_dut (
		.clk            (clk),
		.reset          (reset),
		.start_ker_read (start_ker_read),
		.cfg            (cfg),
		.ker_read_busy  (ker_read_busy),
		.ker_read_done  (ker_read_done),
		.banks          (banks)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD/2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_error(input string name, input int got, input int exp);
		stop_run($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ==============================
	// reference model
	// ==============================
	// addr = offset + kernel * normal_length + word
	task automatic build_model(input read_cfg_t c);
		int len;
		int ofs;
		len = int'(c.normal_length);
		ofs = 0;
		if (c.row_kind == ROW_TOP) begin
			len = int'(c.toppad_length);
			ofs = int'(c.top_starter);
		end else if (c.row_kind == ROW_BOT) begin
			len = int'(c.botpad_length);
		end
		exp_addr.delete();
		exp_fin.delete();
		for (int k = 0; k <= int'(c.kernum_sub1); k++) begin
			for (int col = 0; col <= int'(c.colout_sub1); col++) begin
				for (int w = 0; w < len; w++) begin
					exp_addr.push_back(ofs + k * int'(c.normal_length) + w);
					exp_fin.push_back(w == len - 1);
				end
			end
		end
	endtask

	// ==============================
	// bank monitor
	// ==============================
	// sampled on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (mon_on) begin
			for (int k = 0; k < `KS_BANKS; k++) begin
				if (!banks[k].cen) begin
					assert (int'(banks[k].addr) == exp_addr[low_cnt[k]])
						else value_error($sformatf("banks[%0d].addr", k),
							banks[k].addr, exp_addr[low_cnt[k]]);
					if (k == 0) begin
						b0_cyc.push_back(cyc);
					end else begin
						// same word reaches bank k exactly k cycles after bank 0
						assert (cyc == b0_cyc[low_cnt[k]] + k)
							else value_error($sformatf("banks[%0d].cen cycle", k),
								cyc, b0_cyc[low_cnt[k]] + k);
					end
					low_cnt[k]++;
				end else begin
					assert (banks[k].addr == '0)
						else value_error($sformatf("banks[%0d].addr idle", k), banks[k].addr, 0);
				end
				// one cycle of read latency
				assert (banks[k].valid == prev_low[k])
					else value_error($sformatf("banks[%0d].valid", k), banks[k].valid, prev_low[k]);
				if (banks[k].valid) begin
					assert (banks[k].final_flag == exp_fin[val_cnt[k]])
						else value_error($sformatf("banks[%0d].final_flag", k),
							banks[k].final_flag, exp_fin[val_cnt[k]]);
					val_cnt[k]++;
				end else begin
					assert (!banks[k].final_flag)
						else value_error($sformatf("banks[%0d].final_flag", k), 1, 0);
				end
				if (banks[k].final_flag) begin
					fin_cnt[k]++;
				end
				prev_low[k] = !banks[k].cen;
			end
			if (ker_read_done) begin
				assert (!prev_done)
					else stop_run("ker_read_done stayed high for more than one cycle");
				done_cnt++;
			end
			prev_done = ker_read_done;
		end
	end

	// ==============================
	// stimulus
	// ==============================
	initial begin
		read_cfg_t c;
		int        b;
		int        words;
		int        finals;
		int        waited;
		reset = 1'b1;
		start_ker_read = 1'b0;
		cfg = '0;
		mon_on = 1'b0;
		loaded = 1'b0;
		prev_done = 1'b0;
		seed = 32'haff3a7d1;
		for (int k = 0; k < `KS_BANKS; k++) begin
			prev_low[k] = 1'b0;
		end
		// upper half all ones marks a slot the cases file left empty
		for (int i = 0; i < MAX_CASES * NCOLS; i++) begin
			case_mem[i] = {16'hffff, 16'(i)};
		end
		$readmemh("tests/kersram_cases.txt", case_mem);
		n_cases = 0;
		while (n_cases < MAX_CASES && case_mem[n_cases * NCOLS][31:16] != 16'hffff) begin
			n_cases++;
		end
		assert (n_cases > 0)
			else stop_run("no cases found in tests/kersram_cases.txt");
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// idle outputs straight after reset
		for (int k = 0; k < `KS_BANKS; k++) begin
			assert (banks[k].cen && banks[k].addr == '0 && !banks[k].valid && !banks[k].final_flag)
				else stop_run($sformatf("bank %0d is not idle after reset", k));
		end
		assert (!ker_read_busy && !ker_read_done)
			else stop_run("busy or done is set after reset");
		mon_on = 1'b1;
		for (int n = 0; n < n_cases; n++) begin
			b = n * NCOLS;
			c.row_kind = row_kind_e'(case_mem[b][1:0]);
			c.top_starter = case_mem[b+1][`KS_OFS_BITS-1:0];
			c.toppad_length = case_mem[b+2][`KS_OFS_BITS-1:0];
			c.botpad_length = case_mem[b+3][`KS_OFS_BITS-1:0];
			c.normal_length = case_mem[b+4][`KS_ADDR_BITS-1:0];
			c.colout_sub1 = case_mem[b+5][`KS_ADDR_BITS-1:0];
			c.kernum_sub1 = case_mem[b+6][`KS_KER_BITS-1:0];
			words = int'(case_mem[b+7]);
			finals = int'(case_mem[b+8]);
			build_model(c);
			assert (exp_addr.size() == words)
				else value_error("model word count", exp_addr.size(), words);
			b0_cyc.delete();
			done_cnt = 0;
			for (int k = 0; k < `KS_BANKS; k++) begin
				low_cnt[k] = 0;
				val_cnt[k] = 0;
				fin_cnt[k] = 0;
			end
			@(posedge clk);
			cfg <= c;
			start_ker_read <= 1'b1;
			@(negedge clk);
			assert (!ker_read_busy) else value_error("ker_read_busy", ker_read_busy, 0);
			@(posedge clk);
			start_ker_read <= 1'b0;
			@(negedge clk);
			assert (ker_read_busy) else value_error("ker_read_busy", ker_read_busy, 1);
			// stray start while busy must not add words
			@(posedge clk);
			start_ker_read <= 1'b1;
			@(posedge clk);
			start_ker_read <= 1'b0;
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!ker_read_done && waited < words + 40);
			assert (ker_read_done)
				else stop_run($sformatf("case %0d never raised ker_read_done", n));
			// let the last bank drain
			repeat (`KS_BANKS + 4) @(negedge clk);
			for (int k = 0; k < `KS_BANKS; k++) begin
				assert (low_cnt[k] == words)
					else value_error($sformatf("banks[%0d] cen-low count", k), low_cnt[k], words);
				assert (val_cnt[k] == words)
					else value_error($sformatf("banks[%0d] valid count", k), val_cnt[k], words);
				assert (fin_cnt[k] == finals)
					else value_error($sformatf("banks[%0d] final count", k), fin_cnt[k], finals);
			end
			assert (done_cnt == 1) else value_error("ker_read_done pulses", done_cnt, 1);
			assert (!ker_read_busy) else value_error("ker_read_busy", ker_read_busy, 0);
			seed = lcg_next(seed);
			repeat (int'(seed[18:16])) @(posedge clk);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

	// ==============================
	// watchdog
	// ==============================
	// budget is words plus 40 cycles per case
	initial begin
		longint budget;
		budget = 0;
		wait (loaded);
		for (int n = 0; n < n_cases; n++) begin
			budget += longint'(case_mem[n * NCOLS + 7]) + 40;
		end
		#(budget * PERIOD);
		stop_run("watchdog expired before all cases finished");
	end

endmodule

/* tests/kersram_cases.txt */
// row_kind top_starter toppad_length botpad_length normal_length colout_sub1 kernum_sub1
// expected words, expected finals; all hex, row_kind 0 mid 1 top 2 bottom
0 0 0 0 9 2 3 6c c
0 0 0 0 4 0 0 4 1
0 0 0 0 1 0 0 1 1
0 0 0 0 10 1 3 80 8
1 3 6 5 9 1 2 24 6
1 2 1 0 3 0 4 5 5
1 10 4 0 20 2 5 48 12
2 4 7 6 9 2 1 24 6
2 0 0 2 5 3 0 8 4
2 0 0 3 7 0 7 18 8

/* project.f */
+incdir+logic
logic/kersram_pkg.sv
logic/kernel_read_ctrl.sv
logic/addr_sweep.sv
logic/bank_stagger.sv
logic/kersram_read.sv
tests/kersram_read_tb.sv

/* Makefile */
TOOL    = verilator
TOP     = kersram_read_tb
FLIST   = project.f
FLAGS   = --timing --assert -Wno-fatal
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
